// File: pipe16.f
+incdir+rtl
rtl/pipe16_pkg.sv
rtl/fetch_unit.sv
rtl/ifid_reg.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/reg_file.sv
rtl/pipe16_top.sv
tb/pipe16_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build pipe16 with Verilator, run it, and decide the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module pipe16_tb -f pipe16.f -o pipe16_sim || { echo "build failed"; exit 1; }
./obj_dir/pipe16_sim > sim.log 2>&1 || true
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; } || { echo "simulation done"; exit 0; }

// File: tb/pipe16_tb.sv
// Self-checking pipe16 testbench; every program must reach HALT within 4000 cycles and fit in 256 words
`timescale 1ns/1ps
`include "pipe16_settings.svh"

module pipe16_tb;
	import pipe16_pkg::*;

	localparam int HALT_TIMEOUT = 4000;   // Cycles allowed per program
	localparam int MODEL_STEPS  = 4096;   // Guard against a looping program

	// Expected state from the ISA model
	typedef struct packed {
		logic            done;
		pc_t             halt_pc;
		word_t [15:0]    regs;
	} model_result_t;

	logic        clk;
	logic        reset;
	logic        prog_we;
	imem_addr_t  prog_addr;
	instr_t      prog_data;
	reg_addr_t   dbg_addr;
	word_t       dbg_data;
	logic        halted;
	pc_t         halt_pc;

	instr_t      prog [`PIPE16_IMEM_DEPTH];   // Program image also read by the model
	imem_addr_t  wr_ptr;
	logic [31:0] rng_state;

	pipe16_top dut0 (.clk, .reset, .prog_we, .prog_addr, .prog_data,
		.dbg_addr, .dbg_data, .halted, .halt_pc);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;   // 100 ns period
	end

	function automatic logic [31:0] next_random(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Instruction encoders
	function automatic instr_t alu_word(input opcode_t op, input int rd, input int rs, input int rt);
		return {op, 4'(rd), 4'(rs), 4'(rt)};   // rt doubles as imm4 for ADDI
	endfunction

	function automatic instr_t lli_word(input int rd, input int imm);
		return {`PIPE16_OP_LLI, 4'(rd), 8'(imm)};
	endfunction

	function automatic instr_t branch_word(input int cond, input int off);
		return {`PIPE16_OP_B, 1'b0, 3'(cond), 8'(off)};   // Offset from the branch itself
	endfunction

	function automatic instr_t call_word(input int target);
		return {`PIPE16_OP_CALL, 12'(target)};
	endfunction

	// ISA model stepping one instruction at a time
	function automatic model_result_t pipe16_model();
		model_result_t res;
		word_t         rf [16];
		pc_t           pc;
		instr_t        ins;
		word_t         v;
		logic          zf;
		logic          nf;
		logic          sets;
		logic          take;
		res  = '0;
		pc   = '0;
		zf   = 1'b0;
		nf   = 1'b0;
		for (int i = 0; i < 16; i++)
			rf[i] = '0;
		for (int step = 0; step < MODEL_STEPS && !res.done; step++) begin
			ins  = prog[pc[7:0]];
			sets = 1'b1;
			take = 1'b0;
			v    = '0;
			case (ins[15:12])
				`PIPE16_OP_ADD:  v = rf[ins[7:4]] + rf[ins[3:0]];
				`PIPE16_OP_SUB:  v = rf[ins[7:4]] - rf[ins[3:0]];
				`PIPE16_OP_AND:  v = rf[ins[7:4]] & rf[ins[3:0]];
				`PIPE16_OP_OR:   v = rf[ins[7:4]] | rf[ins[3:0]];
				`PIPE16_OP_ADDI: v = rf[ins[7:4]] + {12'h000, ins[3:0]};
				`PIPE16_OP_LLI:  v = {8'h00, ins[7:0]};
				`PIPE16_OP_B: begin
					sets = 1'b0;
					case (ins[10:8])
						3'd0: take = !zf;
						3'd1: take = zf;
						3'd2: take = !zf && !nf;   // Strictly positive
						3'd3: take = nf;
						3'd4: take = !nf;
						3'd5: take = zf || nf;
						3'd6: take = 1'b0;
						default: take = 1'b1;
					endcase
				end
				`PIPE16_OP_CALL: begin
					sets = 1'b0;
					rf[`PIPE16_LINK_REG] = pc + 16'd1;
				end
				`PIPE16_OP_HALT: begin
					sets        = 1'b0;
					res.done    = 1'b1;
					res.halt_pc = pc;
				end
				default: sets = 1'b0;   // NOP and unused codes
			endcase
			if (sets) begin
				rf[ins[11:8]] = v;
				zf = (v == '0);
				nf = v[15];
			end
			if (ins[15:12] == `PIPE16_OP_CALL)
				pc = {4'h0, ins[11:0]};
			else if (take)
				pc = pc + {{8{ins[7]}}, ins[7:0]};
			else if (!res.done)
				pc = pc + 16'd1;
		end
		for (int i = 0; i < 16; i++)
			res.regs[i] = rf[i];
		return res;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			abort_run($sformatf("ERROR %s: expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic check_pc(input string name, input pc_t expected, input pc_t actual);
		if (actual !== expected) begin
			abort_run($sformatf("ERROR %s: expected %h actual %h", name, expected, actual));
		end
	endtask

	// Every word differs and all decode as NOP
	task automatic clear_program();
		for (int i = 0; i < `PIPE16_IMEM_DEPTH; i++)
			prog[i] = {`PIPE16_OP_NOP, 4'h0, 8'(i)};
		wr_ptr = '0;
	endtask

	task automatic emit(input instr_t w);
		prog[wr_ptr] = w;
		wr_ptr = wr_ptr + 1'b1;
	endtask

	// Load under reset then run to HALT and compare every register
	task automatic run_program(input string name);
		model_result_t exp;
		int            cyc;
		exp = pipe16_model();
		if (!exp.done)
			abort_run($sformatf("Reference model never reached HALT in %s", name));
		@(posedge clk);
		#1;
		reset = 1'b1;
		for (int a = 0; a < `PIPE16_IMEM_DEPTH; a++) begin
			@(posedge clk);
			#1;
			prog_we   = 1'b1;
			prog_addr = imem_addr_t'(a);
			prog_data = prog[a];
		end
		@(posedge clk);
		#1;
		prog_we = 1'b0;
		repeat (5) begin   // Reset stays up 5 cycles past the load
			@(posedge clk);
			#1;
		end
		reset = 1'b0;
		cyc = 0;
		while (!halted) begin
			if (cyc == HALT_TIMEOUT)
				abort_run($sformatf("Core never raised halted while running %s", name));
			@(negedge clk);   // Mid-cycle sample
			cyc++;
		end
		for (int i = 0; i < 16; i++) begin
			@(posedge clk);
			#1;
			dbg_addr = 4'(i);
			@(negedge clk);
			check_word($sformatf("%s r%0d", name, i), exp.regs[i], dbg_data);
		end
		check_pc({name, " halt_pc"}, exp.halt_pc, halt_pc);
	endtask

	initial begin
		int n;
		int k;
		reset     = 1'b1;
		prog_we   = 1'b0;
		prog_addr = '0;
		prog_data = `PIPE16_NOP;
		dbg_addr  = '0;
		rng_state = 32'h1390_340c;

		// Back-to-back dependent ALU ops
		clear_program();
		emit(lli_word(1, 8'h3C));
		emit(lli_word(2, 8'h05));
		emit(alu_word(`PIPE16_OP_ADD, 3, 1, 2));
		emit(alu_word(`PIPE16_OP_SUB, 4, 3, 2));
		emit(alu_word(`PIPE16_OP_AND, 5, 4, 3));
		emit(alu_word(`PIPE16_OP_OR, 6, 5, 2));
		emit(alu_word(`PIPE16_OP_ADD, 6, 6, 6));
		emit(alu_word(`PIPE16_OP_SUB, 7, 2, 6));   // Goes negative
		emit(alu_word(`PIPE16_OP_OR, 8, 7, 1));
		emit(alu_word(`PIPE16_OP_AND, 9, 8, 8));
		emit(alu_word(`PIPE16_OP_ADD, 10, 9, 3));
		emit(alu_word(`PIPE16_OP_SUB, 10, 10, 10));
		emit(alu_word(`PIPE16_OP_ADD, 11, 3, 4));
		emit({`PIPE16_OP_HALT, 12'h000});
		run_program("alu chain");

		// Constants and 16-bit wrap
		clear_program();
		emit(lli_word(1, 8'hFF));
		emit(alu_word(`PIPE16_OP_ADD, 2, 1, 1));
		emit(lli_word(3, 1));
		emit(alu_word(`PIPE16_OP_SUB, 4, 0, 3));    // 16'hFFFF
		emit(alu_word(`PIPE16_OP_ADDI, 5, 4, 15));  // Wraps to E
		emit(alu_word(`PIPE16_OP_ADDI, 6, 4, 1));   // Wraps to 0
		emit(alu_word(`PIPE16_OP_ADDI, 7, 7, 9));
		emit(alu_word(`PIPE16_OP_ADDI, 7, 7, 15));
		emit(lli_word(8, 8'h80));
		emit(alu_word(`PIPE16_OP_OR, 9, 8, 1));
		emit({`PIPE16_OP_HALT, 12'h000});
		run_program("constants");

		// Each condition against zero, negative and positive flags
		clear_program();
		emit(lli_word(12, 1));
		for (n = 0; n < 8; n++) begin
			for (k = 0; k < 3; k++) begin
				if (k == 0)
					emit(lli_word(1, 0));
				else if (k == 1)
					emit(alu_word(`PIPE16_OP_SUB, 1, 0, 12));
				else
					emit(lli_word(1, 5));
				emit(branch_word(n, 3));                      // Skips two when taken
				emit(alu_word(`PIPE16_OP_ADDI, 2 + n, 2 + n, 1));
				emit(alu_word(`PIPE16_OP_ADDI, 10, 10, 1));
			end
		end
		emit(lli_word(13, 4));   // Backward loop of four passes
		emit(alu_word(`PIPE16_OP_ADDI, 14, 14, 3));
		emit(alu_word(`PIPE16_OP_SUB, 13, 13, 12));
		emit(branch_word(0, 8'hFE));
		emit(alu_word(`PIPE16_OP_ADDI, 11, 11, 5));
		emit(alu_word(`PIPE16_OP_ADDI, 11, 11, 6));
		emit({`PIPE16_OP_HALT, 12'h000});
		run_program("branches");

		// Two calls whose next slot must be squashed
		clear_program();
		emit(lli_word(1, 7));
		emit(call_word(12'h040));
		emit(alu_word(`PIPE16_OP_ADDI, 2, 2, 1));
		emit(lli_word(3, 8'h55));
		emit({`PIPE16_OP_HALT, 12'h000});
		wr_ptr = 8'h40;
		emit(alu_word(`PIPE16_OP_ADD, 4, 15, 1));   // Reads link right away
		emit(call_word(12'h003));
		emit(alu_word(`PIPE16_OP_ADDI, 5, 5, 1));
		run_program("call");

		// Code past HALT stays dead
		clear_program();
		emit(lli_word(1, 9));
		emit(alu_word(`PIPE16_OP_ADDI, 2, 1, 1));
		emit({`PIPE16_OP_HALT, 12'h000});
		emit(lli_word(1, 8'hAA));
		emit(alu_word(`PIPE16_OP_ADDI, 3, 3, 7));
		emit(alu_word(`PIPE16_OP_ADD, 4, 1, 1));
		emit(alu_word(`PIPE16_OP_OR, 5, 1, 2));
		emit({`PIPE16_OP_HALT, 12'h000});
		run_program("halt");

		// Random straight-line programs
		for (n = 0; n < 20; n++) begin
			clear_program();
			for (k = 0; k < 24; k++) begin
				rng_state = next_random(rng_state);
				emit({opcode_t'(rng_state[31:16] % 16'd6), rng_state[11:0]});   // Opcodes 0 to 5
			end
			emit({`PIPE16_OP_HALT, 12'h000});
			run_program($sformatf("random %0d", n));
		end

		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: rtl/pipe16_top.sv
// pipe16 core top; program is written through prog_we while reset is held, registers read via dbg
`timescale 1ns/1ps

module pipe16_top (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   prog_we,
	input  pipe16_pkg::imem_addr_t prog_addr,
	input  pipe16_pkg::instr_t     prog_data,
	input  pipe16_pkg::reg_addr_t  dbg_addr,
	output pipe16_pkg::word_t      dbg_data,
	output logic                   halted,
	output pipe16_pkg::pc_t        halt_pc
);
	import pipe16_pkg::*;

	ifid_t     fetched;
	ifid_t     ifid;
	id_ex_t    id_ex;
	ex_wb_t    ex_wb;
	redirect_t ex_redirect;
	redirect_t id_redirect;
	logic      data_hazard;
	reg_addr_t rs_addr;
	reg_addr_t rt_addr;
	word_t     rs_data;
	word_t     rt_data;
	logic      wr_en;
	reg_addr_t wr_addr;
	word_t     wr_data;

	fetch_unit fetch0 (.clk, .reset, .prog_we, .prog_addr, .prog_data,
		.stall(data_hazard), .halted, .ex_redirect, .id_redirect, .fetched);

	ifid_reg ifid0 (.clk, .reset, .fetched, .data_hazard,
		.pc_hazard(ex_redirect.taken), .call(id_redirect.taken), .ifid);

	decode_stage decode0 (.clk, .reset, .ifid, .rs_data, .rt_data,
		.flush(ex_redirect.taken), .rs_addr, .rt_addr, .data_hazard, .id_redirect, .id_ex);

	execute_stage execute0 (.clk, .reset, .id_ex, .halted, .ex_redirect, .ex_wb);

	result_stage result0 (.clk, .reset, .ex_wb, .wr_en, .wr_addr, .wr_data,
		.halted, .halt_pc);

	reg_file regs0 (.clk, .reset, .rs_addr, .rt_addr, .rs_data, .rt_data,
		.wr_en, .wr_addr, .wr_data, .dbg_addr, .dbg_data);

endmodule

// File: rtl/reg_file.sv
// Sixteen 16-bit registers, all cleared on reset; same-cycle write data is seen on rs and rt reads
`timescale 1ns/1ps

module reg_file (
	input  logic                  clk,
	input  logic                  reset,
	input  pipe16_pkg::reg_addr_t rs_addr,
	input  pipe16_pkg::reg_addr_t rt_addr,
	output pipe16_pkg::word_t     rs_data,
	output pipe16_pkg::word_t     rt_data,
	input  logic                  wr_en,
	input  pipe16_pkg::reg_addr_t wr_addr,
	input  pipe16_pkg::word_t     wr_data,
	input  pipe16_pkg::reg_addr_t dbg_addr,
	output pipe16_pkg::word_t     dbg_data
);
	import pipe16_pkg::*;

	word_t regs [16];

	always_ff @(posedge clk) begin
		if (reset)
			regs <= '{default: '0};
		else if (wr_en)
			regs[wr_addr] <= wr_data;
	end

	// Write-through so decode never waits on EX/WB
	assign rs_data = (wr_en && (wr_addr == rs_addr)) ? wr_data : regs[rs_addr];
	assign rt_data = (wr_en && (wr_addr == rt_addr)) ? wr_data : regs[rt_addr];

	assign dbg_data = regs[dbg_addr];   // Plain read, for the testbench

endmodule

// File: rtl/result_stage.sv
// Write-back and halt; halted is sticky until reset and blocks every later register write
`timescale 1ns/1ps

module result_stage (
	input  logic                  clk,
	input  logic                  reset,
	input  pipe16_pkg::ex_wb_t    ex_wb,
	output logic                  wr_en,
	output pipe16_pkg::reg_addr_t wr_addr,
	output pipe16_pkg::word_t     wr_data,
	output logic                  halted,
	output pipe16_pkg::pc_t       halt_pc
);

	// Register file write port
	assign wr_en   = ex_wb.valid && ex_wb.wr_en && !halted;
	assign wr_addr = ex_wb.rd;
	assign wr_data = ex_wb.value;

	// First valid HALT wins
	always_ff @(posedge clk) begin
		if (reset) begin
			halted  <= 1'b0;
			halt_pc <= '0;
		end else if (ex_wb.valid && ex_wb.halt && !halted) begin
			halted  <= 1'b1;
			halt_pc <= ex_wb.pc;   // Address of the HALT itself
		end
	end

endmodule

// File: rtl/execute_stage.sv
// Execute; flags come only from ALU, ADDI and LLI results, branch offset is relative to the branch
`timescale 1ns/1ps
`include "pipe16_settings.svh"

module execute_stage (
	input  logic                  clk,
	input  logic                  reset,
	input  pipe16_pkg::id_ex_t    id_ex,
	input  logic                  halted,
	output pipe16_pkg::redirect_t ex_redirect,
	output pipe16_pkg::ex_wb_t    ex_wb
);
	import pipe16_pkg::*;

	word_t  value;
	logic   zero_flag;
	logic   neg_flag;
	logic   sets_flags;
	logic   cond_met;
	ex_wb_t ex_wb_next;

	// Result select
	always_comb begin
		sets_flags = 1'b1;
		case (id_ex.op)
			`PIPE16_OP_ADD:  value = id_ex.a + id_ex.b;
			`PIPE16_OP_SUB:  value = id_ex.a - id_ex.b;
			`PIPE16_OP_AND:  value = id_ex.a & id_ex.b;
			`PIPE16_OP_OR:   value = id_ex.a | id_ex.b;
			`PIPE16_OP_ADDI: value = id_ex.a + {12'h000, id_ex.imm8[3:0]};   // Wraps at 16 bits
			`PIPE16_OP_LLI:  value = {8'h00, id_ex.imm8};
			`PIPE16_OP_CALL: begin
				value      = id_ex.pc + 16'd1;   // Link value
				sets_flags = 1'b0;
			end
			default: begin
				value      = '0;
				sets_flags = 1'b0;
			end
		endcase
	end

	// Flags left by the last flag-setting op
	always_ff @(posedge clk) begin
		if (reset) begin
			zero_flag <= 1'b0;
			neg_flag  <= 1'b0;
		end else if (id_ex.valid && sets_flags && !halted) begin
			zero_flag <= (value == '0);
			neg_flag  <= value[15];
		end
	end

	// Condition decode
	always_comb begin
		case (id_ex.cond)
			3'd0: cond_met = !zero_flag;
			3'd1: cond_met = zero_flag;
			3'd2: cond_met = !zero_flag && !neg_flag;   // Greater
			3'd3: cond_met = neg_flag;
			3'd4: cond_met = !neg_flag;
			3'd5: cond_met = zero_flag || neg_flag;
			3'd6: cond_met = 1'b0;                      // Never
			default: cond_met = 1'b1;                   // Always
		endcase
	end

	assign ex_redirect.taken  = id_ex.valid && (id_ex.op == `PIPE16_OP_B) && cond_met;
	assign ex_redirect.target = id_ex.pc + {{8{id_ex.imm8[7]}}, id_ex.imm8};

	always_comb begin
		ex_wb_next.valid = id_ex.valid;
		ex_wb_next.rd    = id_ex.rd;
		ex_wb_next.wr_en = id_ex.wr_en;
		ex_wb_next.halt  = (id_ex.op == `PIPE16_OP_HALT);
		ex_wb_next.pc    = id_ex.pc;
		ex_wb_next.value = value;
	end

	// EX/WB register, frozen once halted
	always_ff @(posedge clk) begin
		if (reset)
			ex_wb.valid <= 1'b0;
		else if (!halted)
			ex_wb <= ex_wb_next;
	end

endmodule

// File: rtl/decode_stage.sv
// Decode with stall-based hazards only; ADDI takes imm4 zero-extended, CALL target is 12-bit absolute
`timescale 1ns/1ps
`include "pipe16_settings.svh"

module decode_stage (
	input  logic                  clk,
	input  logic                  reset,
	input  pipe16_pkg::ifid_t     ifid,
	input  pipe16_pkg::word_t     rs_data,
	input  pipe16_pkg::word_t     rt_data,
	input  logic                  flush,          // Execute redirect
	output pipe16_pkg::reg_addr_t rs_addr,
	output pipe16_pkg::reg_addr_t rt_addr,
	output logic                  data_hazard,
	output pipe16_pkg::redirect_t id_redirect,
	output pipe16_pkg::id_ex_t    id_ex
);
	import pipe16_pkg::*;

	opcode_t   op;
	reg_addr_t rd;
	logic      uses_rs;
	logic      uses_rt;
	logic      writes;
	id_ex_t    id_ex_next;

	// Field split
	assign op      = ifid.instr[15:12];
	assign rs_addr = ifid.instr[7:4];
	assign rt_addr = ifid.instr[3:0];
	assign rd      = (op == `PIPE16_OP_CALL) ? `PIPE16_LINK_REG : ifid.instr[11:8];

	// Source and destination use by opcode
	always_comb begin
		uses_rs = 1'b0;
		uses_rt = 1'b0;
		writes  = 1'b0;
		case (op)
			`PIPE16_OP_ADD, `PIPE16_OP_SUB, `PIPE16_OP_AND, `PIPE16_OP_OR: begin
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				writes  = 1'b1;
			end
			`PIPE16_OP_ADDI: begin
				uses_rs = 1'b1;
				writes  = 1'b1;
			end
			`PIPE16_OP_LLI, `PIPE16_OP_CALL: begin
				writes = 1'b1;   // No sources
			end
			default: begin
				writes = 1'b0;   // B, HALT, NOP
			end
		endcase
	end

	// RAW against the entry now in ID/EX; EX/WB is covered by write-through
	assign data_hazard = id_ex.valid && id_ex.wr_en &&
		((uses_rs && (rs_addr == id_ex.rd)) || (uses_rt && (rt_addr == id_ex.rd)));

	assign id_redirect.taken  = (op == `PIPE16_OP_CALL) && !data_hazard && !flush;
	assign id_redirect.target = {4'h0, ifid.instr[11:0]};

	always_comb begin
		id_ex_next.valid = !(flush || data_hazard);   // Bubble on stall or flush
		id_ex_next.op    = op;
		id_ex_next.rd    = rd;
		id_ex_next.a     = rs_data;
		id_ex_next.b     = rt_data;
		id_ex_next.imm8  = ifid.instr[7:0];
		id_ex_next.cond  = ifid.instr[10:8];
		id_ex_next.pc    = ifid.pc;
		id_ex_next.wr_en = writes;
	end

	// ID/EX register, only valid is reset
	always_ff @(posedge clk) begin
		if (reset)
			id_ex.valid <= 1'b0;
		else
			id_ex <= id_ex_next;
	end

endmodule

// File: rtl/ifid_reg.sv
// Flush wins over a data hazard and a flushed slot keeps its old PC
`timescale 1ns/1ps
`include "pipe16_settings.svh"

module ifid_reg (
	input  logic              clk,
	input  logic              reset,
	input  pipe16_pkg::ifid_t fetched,
	input  logic              data_hazard,   // Hold contents
	input  logic              pc_hazard,     // Branch taken in execute
	input  logic              call,          // CALL redirect from decode
	output pipe16_pkg::ifid_t ifid
);

	logic flush;

	assign flush = pc_hazard | call;

	always_ff @(posedge clk) begin
		if (reset) begin
			ifid.pc    <= '0;
			ifid.instr <= `PIPE16_NOP;   // Start empty
		end else if (flush) begin
			ifid.instr <= `PIPE16_NOP;   // Squash the wrong-path word
		end else if (!data_hazard) begin
			ifid <= fetched;
		end
		// Data hazard alone holds everything
	end

endmodule

// File: rtl/fetch_unit.sv
// Fetch with combinational program read; only the low PC bits address the memory, writes any time
`timescale 1ns/1ps
`include "pipe16_settings.svh"

module fetch_unit (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   prog_we,
	input  pipe16_pkg::imem_addr_t prog_addr,
	input  pipe16_pkg::instr_t     prog_data,
	input  logic                   stall,
	input  logic                   halted,
	input  pipe16_pkg::redirect_t  ex_redirect,
	input  pipe16_pkg::redirect_t  id_redirect,
	output pipe16_pkg::ifid_t      fetched
);
	import pipe16_pkg::*;

	instr_t imem [`PIPE16_IMEM_DEPTH];   // Program memory, no reset
	pc_t    pc;

	// Program load port
	always_ff @(posedge clk) begin
		if (prog_we)
			imem[prog_addr] <= prog_data;
	end

	// Execute redirect beats decode redirect, both beat the stall
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (!halted) begin
			if (ex_redirect.taken)
				pc <= ex_redirect.target;   // Branch taken
			else if (id_redirect.taken)
				pc <= id_redirect.target;   // CALL
			else if (!stall)
				pc <= pc + 16'd1;
		end
	end

	assign fetched.pc    = pc;
	assign fetched.instr = imem[imem_addr_t'(pc)];

endmodule

// File: rtl/pipe16_pkg.sv
// Shared types of pipe16; program address width follows the memory depth in the settings header
`include "pipe16_settings.svh"

package pipe16_pkg;

	typedef logic [15:0] word_t;        // Register and ALU data
	typedef logic [15:0] instr_t;
	typedef logic [15:0] pc_t;
	typedef logic [$clog2(`PIPE16_IMEM_DEPTH)-1:0] imem_addr_t;
	typedef logic [3:0]  reg_addr_t;
	typedef logic [3:0]  opcode_t;
	typedef logic [2:0]  branch_cond_t;

	// IF/ID contents
	typedef struct packed {
		pc_t    pc;
		instr_t instr;
	} ifid_t;

	// ID/EX contents, valid low marks a bubble
	typedef struct packed {
		logic         valid;
		opcode_t      op;
		reg_addr_t    rd;      // Already r15 for CALL
		word_t        a;       // rs operand
		word_t        b;       // rt operand
		logic [7:0]   imm8;    // imm4 sits in the low nibble
		branch_cond_t cond;
		pc_t          pc;
		logic         wr_en;
	} id_ex_t;

	// EX/WB contents
	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		logic      wr_en;
		logic      halt;
		pc_t       pc;
		word_t     value;
	} ex_wb_t;

	// PC change request from decode or execute
	typedef struct packed {
		logic taken;
		pc_t  target;
	} redirect_t;

endpackage

// File: rtl/pipe16_settings.svh
// Memory depth, opcode values and fixed words of pipe16; the depth must stay a power of two
`ifndef PIPE16_SETTINGS_SVH
`define PIPE16_SETTINGS_SVH

`define PIPE16_IMEM_DEPTH 256     // Program words, indexed by low PC bits
`define PIPE16_NOP        16'hF000
`define PIPE16_LINK_REG   4'd15   // CALL return address lands here

// Opcodes in instr[15:12]
`define PIPE16_OP_ADD  4'h0
`define PIPE16_OP_SUB  4'h1
`define PIPE16_OP_AND  4'h2
`define PIPE16_OP_OR   4'h3
`define PIPE16_OP_ADDI 4'h4
`define PIPE16_OP_LLI  4'h5
`define PIPE16_OP_B    4'h6
`define PIPE16_OP_CALL 4'h7
`define PIPE16_OP_HALT 4'hE
`define PIPE16_OP_NOP  4'hF

`endif
